//--- cpuDefines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// PC loaded on reset
`define CPU_RESET_PC 32'h0000_0000

// Predictor table index width, 32 entries
`define CPU_PRED_BITS 5

`define CPU_NUM_REGS 32  // Integer registers including x0

`endif

//--- cpuPkg.sv
package cpuPkg;

    typedef logic [31:0] wordT;    // Data or address word
    typedef logic [4:0]  regIdxT;  // Register index

    // Immediate formats
    typedef enum logic [2:0] {
        immI, immS, immB, immJ, immU
    } immSelT;

    typedef enum logic [2:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluSlt
    } aluOpT;

    // Operand source in execute
    typedef enum logic [1:0] {
        fwdNone, fwdWb, fwdMem
    } fwdSelT;

    typedef enum logic [1:0] {
        resAlu, resMem, resPcPlus4, resImm
    } resultSelT;

    // Major opcodes of the supported subset
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opOpImm  = 7'b0010011;
    localparam logic [6:0] opOp     = 7'b0110011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;

endpackage

//--- regFile.sv
`timescale 1ns/1ps
`include "cpuDefines.svh"

module regFile (
    input  logic           clk,
    input  cpuPkg::regIdxT a1_i,
    input  cpuPkg::regIdxT a2_i,
    input  cpuPkg::regIdxT a3_i,
    input  logic           we3_i,
    input  cpuPkg::wordT   wd3_i,
    output cpuPkg::wordT   rd1_o,
    output cpuPkg::wordT   rd2_o
);
    import cpuPkg::*;

    wordT regs [`CPU_NUM_REGS];

    // Falling edge write, decode reads the new value in the same cycle
    always_ff @(negedge clk) begin
        if (we3_i && a3_i != '0) begin
            regs[a3_i] <= wd3_i;
        end
    end

    assign rd1_o = (a1_i == '0) ? '0 : regs[a1_i];  // x0 reads zero
    assign rd2_o = (a2_i == '0) ? '0 : regs[a2_i];

endmodule

//--- alu.sv
`timescale 1ns/1ps

module alu (
    input  cpuPkg::wordT  a_i,
    input  cpuPkg::wordT  b_i,
    input  cpuPkg::aluOpT aluOp_i,
    output cpuPkg::wordT  result_o,
    output logic          zero_o
);
    import cpuPkg::*;

    always_comb begin
        case (aluOp_i)
            aluAdd:  result_o = a_i + b_i;
            aluSub:  result_o = a_i - b_i;
            aluAnd:  result_o = a_i & b_i;
            aluOr:   result_o = a_i | b_i;
            aluSlt:  result_o = {31'b0, $signed(a_i) < $signed(b_i)};  // Signed compare
            default: result_o = '0;
        endcase
    end

    // Branch compare uses the subtract result
    assign zero_o = (result_o == '0);

endmodule

//--- branchPredictor.sv
`timescale 1ns/1ps
`include "cpuDefines.svh"

module branchPredictor (
    input  logic                      clk,
    input  logic                      reset,
    input  cpuPkg::wordT              pcF_i,
    output logic                      predTakenF_o,
    output cpuPkg::wordT              predTargetF_o,
    output logic [`CPU_PRED_BITS-1:0] indexF_o,
    input  logic [`CPU_PRED_BITS-1:0] updIndex_i,
    input  cpuPkg::wordT              updPc_i,
    input  cpuPkg::wordT              updTarget_i,
    input  logic                      updBranch_i,
    input  logic                      updJump_i,
    input  logic                      updTaken_i,
    input  logic                      updMispredict_i
);
    import cpuPkg::*;

    localparam int Entries = 1 << `CPU_PRED_BITS;

    logic [`CPU_PRED_BITS-1:0] ghr;  // Global history
    logic [`CPU_PRED_BITS-1:0] btbIdxF, btbIdxU;
    logic [1:0] pht [Entries];
    logic       btbValid [Entries];
    logic       btbJump [Entries];
    wordT       btbTag [Entries];
    wordT       btbTarget [Entries];
    logic       btbHit;

    assign btbIdxF  = pcF_i[`CPU_PRED_BITS+1:2];
    assign btbIdxU  = updPc_i[`CPU_PRED_BITS+1:2];
    assign indexF_o = btbIdxF ^ ghr;  // Gshare hash

    // Full PC tag, so only previously taken PCs can hit
    assign btbHit        = btbValid[btbIdxF] && (btbTag[btbIdxF] == pcF_i);
    assign predTakenF_o  = btbHit && (btbJump[btbIdxF] || pht[indexF_o][1]);
    assign predTargetF_o = btbTarget[btbIdxF];

    always_ff @(posedge clk) begin
        if (reset) begin
            ghr <= '0;
            for (int i = 0; i < Entries; i++) begin
                pht[i]      <= 2'b01;  // Weakly not taken
                btbValid[i] <= 1'b0;
            end
        end else begin
            if (updBranch_i) begin
                if (updTaken_i && pht[updIndex_i] != 2'b11) begin
                    pht[updIndex_i] <= pht[updIndex_i] + 2'd1;
                end else if (!updTaken_i && pht[updIndex_i] != 2'b00) begin
                    pht[updIndex_i] <= pht[updIndex_i] - 2'd1;
                end
            end
            if (updMispredict_i) begin
                ghr <= '0;
            end else if (updBranch_i) begin
                ghr <= {ghr[`CPU_PRED_BITS-2:0], updTaken_i};
            end
            if (updTaken_i) begin
                btbValid[btbIdxU] <= 1'b1;
            end
        end
    end

    // Tag and target written on every taken branch or jump
    always_ff @(posedge clk) begin
        if (updTaken_i) begin
            btbTag[btbIdxU]    <= updPc_i;
            btbJump[btbIdxU]   <= updJump_i;
            btbTarget[btbIdxU] <= updTarget_i;
        end
    end

endmodule

//--- controller.sv
`timescale 1ns/1ps

module controller (
    input  logic              clk,
    input  logic              reset,
    input  logic [6:0]        opD_i,
    input  logic [2:0]        funct3D_i,
    input  logic              funct7b5D_i,
    input  cpuPkg::regIdxT    rs1D_i,
    input  cpuPkg::regIdxT    rs2D_i,
    input  cpuPkg::regIdxT    rs1E_i,
    input  cpuPkg::regIdxT    rs2E_i,
    input  cpuPkg::regIdxT    rdE_i,
    input  cpuPkg::regIdxT    rdM_i,
    input  cpuPkg::regIdxT    rdW_i,
    input  logic              zeroE_i,
    input  logic              predTakenE_i,
    input  logic              targetMatchE_i,
    output cpuPkg::immSelT    immSel_o,
    output logic              aluSrcE_o,
    output cpuPkg::aluOpT     aluOpE_o,
    output cpuPkg::resultSelT resultSelM_o,
    output cpuPkg::resultSelT resultSelW_o,
    output logic              regWriteW_o,
    output logic              memWriteM_o,
    output cpuPkg::fwdSelT    forwardAE_o,
    output cpuPkg::fwdSelT    forwardBE_o,
    output logic              stallF_o,
    output logic              stallD_o,
    output logic              flushD_o,
    output logic              flushE_o,
    output logic              takenE_o,
    output logic              redirectE_o,
    output logic              branchE_o,
    output logic              jumpE_o
);
    import cpuPkg::*;

    logic       regWriteD, aluSrcD, memWriteD, branchD, jumpD;
    resultSelT  resultSelD, resultSelE;
    aluOpT      aluOpD;
    logic       regWriteE, memWriteE, regWriteM;
    logic [2:0] funct3E;
    logic       lwStall;

    // Main decoder
    always_comb begin
        regWriteD  = 1'b0;
        memWriteD  = 1'b0;
        aluSrcD    = 1'b0;
        branchD    = 1'b0;
        jumpD      = 1'b0;
        immSel_o   = immI;
        resultSelD = resAlu;
        case (opD_i)
            opLui: begin
                regWriteD  = 1'b1;
                immSel_o   = immU;
                resultSelD = resImm;
            end
            opOpImm: begin
                regWriteD = 1'b1;
                aluSrcD   = 1'b1;
            end
            opOp: regWriteD = 1'b1;
            opLoad: begin
                regWriteD  = 1'b1;
                aluSrcD    = 1'b1;
                resultSelD = resMem;
            end
            opStore: begin
                memWriteD = 1'b1;
                aluSrcD   = 1'b1;
                immSel_o  = immS;
            end
            opBranch: begin
                branchD  = 1'b1;
                immSel_o = immB;
            end
            opJal: begin
                regWriteD  = 1'b1;
                jumpD      = 1'b1;
                immSel_o   = immJ;
                resultSelD = resPcPlus4;
            end
            opJalr: begin
                regWriteD  = 1'b1;
                jumpD      = 1'b1;
                aluSrcD    = 1'b1;  // rs1 + imm gives the target
                resultSelD = resPcPlus4;
            end
            default: ;
        endcase
    end

    // ALU decoder
    always_comb begin
        aluOpD = aluAdd;
        if (opD_i == opOp || opD_i == opOpImm) begin
            case (funct3D_i)
                3'b000:  aluOpD = (opD_i == opOp && funct7b5D_i) ? aluSub : aluAdd;
                3'b010:  aluOpD = aluSlt;
                3'b110:  aluOpD = aluOr;
                3'b111:  aluOpD = aluAnd;
                default: aluOpD = aluAdd;
            endcase
        end else if (opD_i == opBranch) begin
            aluOpD = aluSub;  // Equality via zero flag
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flushE_o) begin
            regWriteE  <= 1'b0;
            memWriteE  <= 1'b0;
            aluSrcE_o  <= 1'b0;
            branchE_o  <= 1'b0;
            jumpE_o    <= 1'b0;
            aluOpE_o   <= aluAdd;
            resultSelE <= resAlu;
            funct3E    <= '0;
        end else begin
            regWriteE  <= regWriteD;
            memWriteE  <= memWriteD;
            aluSrcE_o  <= aluSrcD;
            branchE_o  <= branchD;
            jumpE_o    <= jumpD;
            aluOpE_o   <= aluOpD;
            resultSelE <= resultSelD;
            funct3E    <= funct3D_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            regWriteM    <= 1'b0;
            memWriteM_o  <= 1'b0;
            resultSelM_o <= resAlu;
            regWriteW_o  <= 1'b0;
            resultSelW_o <= resAlu;
        end else begin
            regWriteM    <= regWriteE;
            memWriteM_o  <= memWriteE;
            resultSelM_o <= resultSelE;
            regWriteW_o  <= regWriteM;
            resultSelW_o <= resultSelM_o;
        end
    end

    // Memory stage wins over writeback
    function automatic fwdSelT fwdSel(input regIdxT rs);
        if (regWriteM && rdM_i != '0 && rdM_i == rs) begin
            return fwdMem;
        end else if (regWriteW_o && rdW_i != '0 && rdW_i == rs) begin
            return fwdWb;
        end
        return fwdNone;
    endfunction

    assign forwardAE_o = fwdSel(rs1E_i);
    assign forwardBE_o = fwdSel(rs2E_i);

    assign lwStall = (resultSelE == resMem) && (rdE_i != '0) &&
                     (rdE_i == rs1D_i || rdE_i == rs2D_i);

    // funct3 bit 0 separates bne from beq
    assign takenE_o    = (branchE_o && (funct3E[0] ? !zeroE_i : zeroE_i)) || jumpE_o;
    assign redirectE_o = takenE_o ? !(predTakenE_i && targetMatchE_i) : predTakenE_i;

    assign stallF_o = lwStall;
    assign stallD_o = lwStall;
    assign flushD_o = redirectE_o;
    assign flushE_o = lwStall || redirectE_o;

endmodule

//--- datapath.sv
`timescale 1ns/1ps
`include "cpuDefines.svh"

module datapath (
    input  logic              clk,
    input  logic              reset,
    input  cpuPkg::immSelT    immSel_i,
    input  logic              aluSrcE_i,
    input  cpuPkg::aluOpT     aluOpE_i,
    input  cpuPkg::resultSelT resultSelM_i,
    input  cpuPkg::resultSelT resultSelW_i,
    input  logic              regWriteW_i,
    input  cpuPkg::fwdSelT    forwardAE_i,
    input  cpuPkg::fwdSelT    forwardBE_i,
    input  logic              stallF_i, stallD_i, flushD_i, flushE_i,
    input  logic              takenE_i, redirectE_i, branchE_i, jumpE_i,
    output cpuPkg::wordT      imemAddr_o,
    input  cpuPkg::wordT      instrF_i,
    output cpuPkg::wordT      dmemAddr_o,
    output cpuPkg::wordT      dmemWdata_o,
    input  cpuPkg::wordT      dmemRdata_i,
    output logic [6:0]        opD_o,
    output logic [2:0]        funct3D_o,
    output logic              funct7b5D_o,
    output cpuPkg::regIdxT    rs1D_o, rs2D_o,
    output cpuPkg::regIdxT    rs1E_o, rs2E_o, rdE_o,
    output cpuPkg::regIdxT    rdM_o, rdW_o,
    output logic              zeroE_o,
    output logic              predTakenE_o,
    output logic              targetMatchE_o
);
    import cpuPkg::*;

    wordT   pcF, pcPlus4F, pcNextF, predTargetF;
    logic   predTakenF, predTakenD;
    logic [`CPU_PRED_BITS-1:0] indexF, indexD, indexE;
    wordT   instrD, pcD, pcPlus4D, predTargetD, immD, rd1D, rd2D;
    regIdxT rdD;
    wordT   rd1E, rd2E, pcE, pcPlus4E, immE, predTargetE;
    wordT   srcAE, srcBE, writeDataE, aluResultE, targetE, redirectPcE;
    logic [6:0] opE;
    wordT   aluResultM, pcPlus4M, immM, fwdDataM;
    wordT   aluResultW, readDataW, pcPlus4W, immW, resultW;

    function automatic wordT pickResult(input resultSelT sel, input wordT alu, mem, pc4, imm);
        case (sel)
            resMem:     return mem;
            resPcPlus4: return pc4;
            resImm:     return imm;
            default:    return alu;
        endcase
    endfunction

    function automatic wordT fwdMux(input fwdSelT sel, input wordT regVal);
        case (sel)
            fwdMem:  return fwdDataM;
            fwdWb:   return resultW;
            default: return regVal;
        endcase
    endfunction

    // Fetch, redirect beats prediction
    assign pcPlus4F   = pcF + 32'd4;
    assign pcNextF    = redirectE_i ? redirectPcE : (predTakenF ? predTargetF : pcPlus4F);
    assign imemAddr_o = pcF;

    always_ff @(posedge clk) begin
        if (reset) begin
            pcF <= `CPU_RESET_PC;
        end else if (!stallF_i) begin
            pcF <= pcNextF;
        end
    end

    branchPredictor bp (
        .clk(clk), .reset(reset), .pcF_i(pcF),
        .predTakenF_o(predTakenF), .predTargetF_o(predTargetF), .indexF_o(indexF),
        .updIndex_i(indexE), .updPc_i(pcE), .updTarget_i(targetE),
        .updBranch_i(branchE_i), .updJump_i(jumpE_i), .updTaken_i(takenE_i),
        .updMispredict_i(redirectE_i)
    );

    always_ff @(posedge clk) begin
        if (reset || flushD_i) begin
            instrD      <= '0;
            pcD         <= '0;
            pcPlus4D    <= '0;
            predTakenD  <= 1'b0;
            predTargetD <= '0;
            indexD      <= '0;
        end else if (!stallD_i) begin
            instrD      <= instrF_i;
            pcD         <= pcF;
            pcPlus4D    <= pcPlus4F;
            predTakenD  <= predTakenF;
            predTargetD <= predTargetF;
            indexD      <= indexF;  // Returned to the predictor at update
        end
    end

    // Decode
    assign opD_o       = instrD[6:0];
    assign funct3D_o   = instrD[14:12];
    assign funct7b5D_o = instrD[30];
    assign rs1D_o      = instrD[19:15];
    assign rs2D_o      = instrD[24:20];
    assign rdD         = instrD[11:7];

    regFile rf (
        .clk(clk), .a1_i(rs1D_o), .a2_i(rs2D_o), .a3_i(rdW_o),
        .we3_i(regWriteW_i), .wd3_i(resultW), .rd1_o(rd1D), .rd2_o(rd2D)
    );

    always_comb begin
        case (immSel_i)
            immS:    immD = {{20{instrD[31]}}, instrD[31:25], instrD[11:7]};
            immB:    immD = {{20{instrD[31]}}, instrD[7], instrD[30:25], instrD[11:8], 1'b0};
            immJ:    immD = {{12{instrD[31]}}, instrD[19:12], instrD[20], instrD[30:21], 1'b0};
            immU:    immD = {instrD[31:12], 12'b0};
            default: immD = {{20{instrD[31]}}, instrD[31:20]};
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset || flushE_i) begin
            rd1E         <= '0;
            rd2E         <= '0;
            pcE          <= '0;
            pcPlus4E     <= '0;
            immE         <= '0;
            rs1E_o       <= '0;
            rs2E_o       <= '0;
            rdE_o        <= '0;
            opE          <= '0;
            predTakenE_o <= 1'b0;
            predTargetE  <= '0;
            indexE       <= '0;
        end else begin
            rd1E         <= rd1D;
            rd2E         <= rd2D;
            pcE          <= pcD;
            pcPlus4E     <= pcPlus4D;
            immE         <= immD;
            rs1E_o       <= rs1D_o;
            rs2E_o       <= rs2D_o;
            rdE_o        <= rdD;
            opE          <= opD_o;
            predTakenE_o <= predTakenD;
            predTargetE  <= predTargetD;
            indexE       <= indexD;
        end
    end

    // Execute
    assign srcAE      = fwdMux(forwardAE_i, rd1E);
    assign writeDataE = fwdMux(forwardBE_i, rd2E);
    assign srcBE      = aluSrcE_i ? immE : writeDataE;

    alu alu (
        .a_i(srcAE), .b_i(srcBE), .aluOp_i(aluOpE_i), .result_o(aluResultE), .zero_o(zeroE_o)
    );

    assign targetE        = (opE == opJalr) ? {aluResultE[31:1], 1'b0} : pcE + immE;
    assign redirectPcE    = takenE_i ? targetE : pcPlus4E;
    assign targetMatchE_o = (predTargetE == targetE);

    always_ff @(posedge clk) begin
        if (reset) begin
            aluResultM  <= '0;
            dmemWdata_o <= '0;
            pcPlus4M    <= '0;
            immM        <= '0;
            rdM_o       <= '0;
            aluResultW  <= '0;
            readDataW   <= '0;
            pcPlus4W    <= '0;
            immW        <= '0;
            rdW_o       <= '0;
        end else begin
            aluResultM  <= aluResultE;
            dmemWdata_o <= writeDataE;
            pcPlus4M    <= pcPlus4E;
            immM        <= immE;
            rdM_o       <= rdE_o;
            aluResultW  <= aluResultM;
            readDataW   <= dmemRdata_i;
            pcPlus4W    <= pcPlus4M;
            immW        <= immM;
            rdW_o       <= rdM_o;
        end
    end

    assign dmemAddr_o = aluResultM;
    assign fwdDataM   = pickResult(resultSelM_i, aluResultM, dmemRdata_i, pcPlus4M, immM);
    assign resultW    = pickResult(resultSelW_i, aluResultW, readDataW, pcPlus4W, immW);

endmodule

//--- riscvCore.sv
`timescale 1ns/1ps

module riscvCore (
    input  logic         clk,
    input  logic         reset,
    output cpuPkg::wordT imemAddr_o,
    input  cpuPkg::wordT imemData_i,
    output cpuPkg::wordT dmemAddr_o,
    output cpuPkg::wordT dmemWdata_o,
    output logic         dmemWe_o,
    input  cpuPkg::wordT dmemRdata_i
);
    import cpuPkg::*;

    immSelT     immSel;
    aluOpT      aluOpE;
    resultSelT  resultSelM, resultSelW;
    fwdSelT     forwardAE, forwardBE;
    logic       aluSrcE, regWriteW, stallF, stallD, flushD, flushE;
    logic       takenE, redirectE, branchE, jumpE;
    logic [6:0] opD;
    logic [2:0] funct3D;
    logic       funct7b5D, zeroE, predTakenE, targetMatchE;
    regIdxT     rs1D, rs2D, rs1E, rs2E, rdE, rdM, rdW;

    controller ctrl (
        .clk(clk), .reset(reset),
        .opD_i(opD), .funct3D_i(funct3D), .funct7b5D_i(funct7b5D),
        .rs1D_i(rs1D), .rs2D_i(rs2D), .rs1E_i(rs1E), .rs2E_i(rs2E),
        .rdE_i(rdE), .rdM_i(rdM), .rdW_i(rdW),
        .zeroE_i(zeroE), .predTakenE_i(predTakenE), .targetMatchE_i(targetMatchE),
        .immSel_o(immSel), .aluSrcE_o(aluSrcE), .aluOpE_o(aluOpE),
        .resultSelM_o(resultSelM), .resultSelW_o(resultSelW),
        .regWriteW_o(regWriteW), .memWriteM_o(dmemWe_o),
        .forwardAE_o(forwardAE), .forwardBE_o(forwardBE),
        .stallF_o(stallF), .stallD_o(stallD), .flushD_o(flushD), .flushE_o(flushE),
        .takenE_o(takenE), .redirectE_o(redirectE), .branchE_o(branchE), .jumpE_o(jumpE)
    );

    datapath dp (
        .clk(clk), .reset(reset),
        .immSel_i(immSel), .aluSrcE_i(aluSrcE), .aluOpE_i(aluOpE),
        .resultSelM_i(resultSelM), .resultSelW_i(resultSelW), .regWriteW_i(regWriteW),
        .forwardAE_i(forwardAE), .forwardBE_i(forwardBE),
        .stallF_i(stallF), .stallD_i(stallD), .flushD_i(flushD), .flushE_i(flushE),
        .takenE_i(takenE), .redirectE_i(redirectE), .branchE_i(branchE), .jumpE_i(jumpE),
        .imemAddr_o(imemAddr_o), .instrF_i(imemData_i),
        .dmemAddr_o(dmemAddr_o), .dmemWdata_o(dmemWdata_o), .dmemRdata_i(dmemRdata_i),
        .opD_o(opD), .funct3D_o(funct3D), .funct7b5D_o(funct7b5D),
        .rs1D_o(rs1D), .rs2D_o(rs2D), .rs1E_o(rs1E), .rs2E_o(rs2E),
        .rdE_o(rdE), .rdM_o(rdM), .rdW_o(rdW),
        .zeroE_o(zeroE), .predTakenE_o(predTakenE), .targetMatchE_o(targetMatchE)
    );

endmodule

//--- tbCore.sv
`timescale 1ns/1ps
`include "cpuDefines.svh"

module tbCore;
    import cpuPkg::*;

    // RV32I base opcodes
    localparam logic [6:0] luiOp    = 7'b0110111;
    localparam logic [6:0] immOp    = 7'b0010011;
    localparam logic [6:0] regOp    = 7'b0110011;
    localparam logic [6:0] loadOp   = 7'b0000011;
    localparam logic [6:0] storeOp  = 7'b0100011;
    localparam logic [6:0] branchOp = 7'b1100011;
    localparam logic [6:0] jalOp    = 7'b1101111;
    localparam logic [6:0] jalrOp   = 7'b1100111;
    localparam int StoreTimeout = 20000;  // Cycles
    localparam int HaltTimeout  = 200;

    logic clk = 1'b0;
    logic reset = 1'b1;
    wordT imemAddr, dmemAddr, dmemWdata;
    wordT imemData = '0;
    wordT dmemRdata = '0;
    logic dmemWe;

    wordT imem [1024];
    wordT dmem [64];      // Seen by the DUT
    wordT modelMem [64];  // Seen by the model
    wordT expAddr [$];
    wordT expData [$];
    int   progLen = 0;
    wordT haltPc;
    logic [4:0] lastRd = 5'd1;

    riscvCore uut (
        .clk(clk), .reset(reset),
        .imemAddr_o(imemAddr), .imemData_i(imemData),
        .dmemAddr_o(dmemAddr), .dmemWdata_o(dmemWdata), .dmemWe_o(dmemWe),
        .dmemRdata_i(dmemRdata)
    );

    always #2 clk = ~clk;

    // Memory read data driven on the falling edge
    always @(negedge clk) begin
        if (dmemWe === 1'b1) begin
            dmem[dmemAddr[7:2]] = dmemWdata;
        end
        imemData  = imem[imemAddr[11:2]];
        dmemRdata = dmem[dmemAddr[7:2]];
    end

    function automatic wordT encR(input logic f7b5, input logic [4:0] rs2, rs1,
                                  input logic [2:0] f3, input logic [4:0] rd);
        return {1'b0, f7b5, 5'b0, rs2, rs1, f3, rd, regOp};
    endfunction

    function automatic wordT encI(input logic [11:0] imm, input logic [4:0] rs1,
                                  input logic [2:0] f3, input logic [4:0] rd,
                                  input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic wordT encS(input logic [11:0] imm, input logic [4:0] rs2, rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], storeOp};
    endfunction

    function automatic wordT encB(input logic [12:0] off, input logic [4:0] rs2, rs1,
                                  input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], branchOp};
    endfunction

    function automatic wordT encJ(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, jalOp};
    endfunction

    task automatic emit(input wordT ins);
        imem[progLen] = ins;
        progLen++;
    endtask

    // One ALU, load or store op that often reads the last result
    task automatic genOp();
        logic [4:0] rd, rs1, rs2;
        rd  = 5'(1 + $urandom % 30);  // x31 stays the loop counter
        rs1 = ($urandom % 2 == 0) ? lastRd : 5'($urandom % 32);
        rs2 = ($urandom % 3 == 0) ? lastRd : 5'($urandom % 32);
        case ($urandom % 9)
            0: emit({20'($urandom), rd, luiOp});
            1: emit(encI(12'($urandom), rs1, 3'b000, rd, immOp));
            2: emit(encR(1'b0, rs2, rs1, 3'b000, rd));
            3: emit(encR(1'b1, rs2, rs1, 3'b000, rd));  // sub
            4: emit(encR(1'b0, rs2, rs1, 3'b111, rd));
            5: emit(encR(1'b0, rs2, rs1, 3'b110, rd));
            6: emit(encR(1'b0, rs2, rs1, 3'b010, rd));
            7: emit(encI(12'(4 * ($urandom % 64)), 5'd0, 3'b010, rd, loadOp));
            default: begin
                emit(encS(12'(4 * ($urandom % 64)), rs2, 5'd0));
                rd = lastRd;  // Stores write no register
            end
        endcase
        lastRd = rd;
    endtask

    task automatic buildProgram();
        int skip, loopStart;
        logic [4:0] r1, r2, rd;
        logic [2:0] f3;
        wordT target;
        for (int r = 1; r < 32; r++) begin
            emit({20'($urandom), 5'(r), luiOp});
            emit(encI(12'($urandom), 5'(r), 3'b000, 5'(r), immOp));
        end
        for (int blk = 0; blk < 40; blk++) begin
            skip = 1 + $urandom % 3;
            rd   = 5'(1 + $urandom % 30);
            case ($urandom % 6)
                2: begin
                    r1 = 5'($urandom % 32);
                    r2 = ($urandom % 3 == 0) ? r1 : 5'($urandom % 32);
                    f3 = ($urandom % 2 == 1) ? 3'b001 : 3'b000;  // bne or beq
                    emit(encB(13'((skip + 1) * 4), r2, r1, f3));
                    repeat (skip) genOp();
                end
                3: begin
                    emit(encJ(21'((skip + 1) * 4), rd));
                    lastRd = rd;
                    repeat (skip) genOp();
                end
                4: begin
                    target = 32'((progLen + 2 + skip) * 4);
                    r1 = 5'(1 + $urandom % 30);
                    emit(encI(12'(target - 8), 5'd0, 3'b000, r1, immOp));
                    emit(encI(12'd8, r1, 3'b000, rd, jalrOp));
                    lastRd = rd;
                    repeat (skip) genOp();
                end
                5: begin
                    emit(encI(12'(2 + $urandom % 4), 5'd0, 3'b000, 5'd31, immOp));
                    loopStart = progLen;
                    repeat (skip + 1) genOp();
                    emit(encI(12'hfff, 5'd31, 3'b000, 5'd31, immOp));  // Count down
                    emit(encB(13'((loopStart - progLen) * 4), 5'd0, 5'd31, 3'b001));
                end
                default: genOp();
            endcase
        end
        for (int r = 1; r < 32; r++) begin
            emit(encS(12'(4 * r), 5'(r), 5'd0));
        end
        haltPc = 32'(progLen * 4);
        emit(encJ(21'd0, 5'd0));  // Self loop
    endtask

    // Instruction-set model that collects the expected stores
    task automatic runModel();
        wordT x [32];
        wordT pc, nextPc, ins, a, b, addr, immI, immS, immB, immJ;
        logic [4:0] rd;
        int steps;
        for (int r = 0; r < 32; r++) begin
            x[r] = '0;
        end
        pc = `CPU_RESET_PC;
        steps = 0;
        while (pc != haltPc && steps < 100000) begin
            ins  = imem[pc[11:2]];
            rd   = ins[11:7];
            a    = x[ins[19:15]];
            b    = x[ins[24:20]];
            immI = {{20{ins[31]}}, ins[31:20]};
            immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            immB = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            immJ = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            nextPc = pc + 32'd4;
            case (ins[6:0])
                luiOp: x[rd] = {ins[31:12], 12'b0};
                immOp: x[rd] = a + immI;
                regOp: begin
                    case (ins[14:12])
                        3'b000:  x[rd] = ins[30] ? a - b : a + b;
                        3'b010:  x[rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        3'b110:  x[rd] = a | b;
                        default: x[rd] = a & b;
                    endcase
                end
                loadOp: begin
                    addr  = a + immI;
                    x[rd] = modelMem[addr[7:2]];
                end
                storeOp: begin
                    addr = a + immS;
                    modelMem[addr[7:2]] = b;
                    expAddr.push_back(addr);
                    expData.push_back(b);
                end
                branchOp: if ((a == b) != ins[12]) nextPc = pc + immB;
                jalOp: begin
                    x[rd]  = pc + 32'd4;
                    nextPc = pc + immJ;
                end
                jalrOp: begin
                    x[rd]  = pc + 32'd4;
                    nextPc = (a + immI) & ~32'd1;
                end
                default: ;
            endcase
            x[0] = '0;
            pc = nextPc;
            steps++;
        end
        if (pc != haltPc) begin
            $display("Model never reached the halt address %h", haltPc);
            failAndStop();
        end
    endtask

    task automatic failAndStop();
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic checkEq(input string name, input wordT got, input wordT exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            failAndStop();
        end
    endtask

    task automatic checkStore();
        if (dmemWe === 1'b1) begin
            if (expAddr.size() == 0) begin
                $display("Store to %h after the model ran out of stores", dmemAddr);
                failAndStop();
            end
            checkEq("dmemAddr_o", dmemAddr, expAddr.pop_front());
            checkEq("dmemWdata_o", dmemWdata, expData.pop_front());
        end
    endtask

    initial begin
        int cyc;
        void'($urandom(32'he90a70fb));
        for (int i = 0; i < 1024; i++) begin
            imem[i] = encI(12'(i), 5'd0, 3'b000, 5'd0, immOp);  // addi x0 as a nop
        end
        for (int i = 0; i < 64; i++) begin
            dmem[i]     = $urandom;
            modelMem[i] = dmem[i];
        end
        buildProgram();
        runModel();
        for (int i = 0; i < 3; i++) begin
            @(negedge clk);
            checkEq("dmemWe_o", {31'b0, dmemWe}, 32'd0);
            checkEq("imemAddr_o", imemAddr, `CPU_RESET_PC);
        end
        reset = 1'b0;
        #1;
        checkEq("dmemWe_o", {31'b0, dmemWe}, 32'd0);  // First cycle out of reset
        checkEq("imemAddr_o", imemAddr, `CPU_RESET_PC);
        for (cyc = 0; cyc < StoreTimeout && expAddr.size() != 0; cyc++) begin
            @(negedge clk);
            checkStore();
        end
        if (expAddr.size() != 0) begin
            $display("Timeout with %0d model stores still missing", expAddr.size());
            failAndStop();
        end
        for (cyc = 0; cyc < HaltTimeout && imemAddr != haltPc; cyc++) begin
            @(negedge clk);
            checkStore();
        end
        if (imemAddr != haltPc) begin
            $display("Timeout waiting for fetch to reach the halt address %h", haltPc);
            failAndStop();
        end else begin
            repeat (50) begin
                @(negedge clk);
                checkStore();
            end
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

//--- tb.f
+incdir+.
cpuPkg.sv
regFile.sv
alu.sv
branchPredictor.sv
controller.sv
datapath.sv
riscvCore.sv
tbCore.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tbCore
FILELIST  = tb.f
OBJDIR    = obj_dir
LOG       = sim.log
PASS_MSG  = Finished with no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
